/* hw/arm_defines.svh */
// Word and register-file sizes, instruction field codes and ALU operation codes
`ifndef ARM_DEFINES_SVH
`define ARM_DEFINES_SVH

// Data and address width
`define ARM_XLEN 32

// Architectural registers, r15 included
`define ARM_NREGS 16
`define ARM_PC_REG 15

// r15 reads as the instruction address plus this amount
`define ARM_PC_AHEAD 8

// Op field, instr[27:26]
`define ARM_OP_DP 2'b00
`define ARM_OP_MEM 2'b01
`define ARM_OP_BR 2'b10

// Condition field value that always executes
`define ARM_COND_AL 4'b1110

// ALU control codes, bit 0 selects subtract in the adder
`define ALU_ADD 3'b000
`define ALU_SUB 3'b001
`define ALU_AND 3'b010
`define ALU_ORR 3'b011
`define ALU_EOR 3'b100
`define ALU_MUL 3'b101

`endif

/* hw/armPkg.sv */
// Processor-wide types: word, register index, condition, flags, ALU control, selects, FSM states
`default_nettype none

package armPkg;

	`include "arm_defines.svh"

	// Data and address word
	typedef logic [`ARM_XLEN-1:0] word_t;

	// Register file index
	typedef logic [$clog2(`ARM_NREGS)-1:0] regAddr_t;

	// Condition field of an instruction
	typedef logic [3:0] cond_t;

	// Ordered as N, Z, C, V from bit 3 down
	typedef logic [3:0] flags_t;

	typedef logic [2:0] aluCtrl_t;

	// Three-way operand, immediate or result select
	typedef logic [1:0] srcSel_t;

	// Multicycle control states
	typedef enum logic [3:0] {
		FETCH,
		DECODE,
		MEMADR,
		MEMRD,
		MEMWB,
		MEMWR,
		EXECUTER,
		EXECUTEI,
		ALUWB,
		BRANCH
	} fsmState_t;

endpackage

`default_nettype wire

/* hw/armIfc.sv */
// Control interfaces fsmCtrlIf (FSM strobes) and dpCtrlIf (datapath controls)
`timescale 1ns/100ps
`default_nettype none

interface fsmCtrlIf;
	logic nextPc;
	logic branch;
	logic regW;
	logic memW;
	logic aluOp;

	modport fsm (output nextPc, branch, regW, memW, aluOp);
	modport dec (input branch, aluOp);
	modport cond (input nextPc, branch, regW, memW);
endinterface

interface dpCtrlIf;
	import armPkg::*;

	logic     irWrite;
	logic     adrSrc;
	srcSel_t  aluSrcA;
	srcSel_t  aluSrcB;
	srcSel_t  resultSrc;
	logic [1:0] regSrc;
	srcSel_t  immSrc;
	aluCtrl_t aluControl;
	logic     mulSel;
	logic     pcWrite;
	logic     regWrite;

	modport fsm (output irWrite, adrSrc, aluSrcA, aluSrcB, resultSrc);
	modport dec (output regSrc, immSrc, aluControl, mulSel);
	modport cond (output pcWrite, regWrite);
	modport dp (input irWrite, adrSrc, aluSrcA, aluSrcB, resultSrc, regSrc, immSrc,
		aluControl, mulSel, pcWrite, regWrite);
endinterface

`default_nettype wire

/* hw/alu.sv */
// alu: add/subtract, AND, ORR, EOR, low-word multiply and NZCV flags
`timescale 1ns/100ps
`default_nettype none

`include "arm_defines.svh"

module alu (
	input  armPkg::word_t    a,
	input  armPkg::word_t    b,
	input  armPkg::aluCtrl_t aluControl,
	output armPkg::word_t    result,
	output armPkg::flags_t   aluFlags
);
	import armPkg::*;

	logic          isSub;
	logic          isAdder;
	word_t         bInv;
	logic [`ARM_XLEN:0] sum;
	logic          carry;
	logic          overflow;

	assign isSub = (aluControl == `ALU_SUB);
	assign isAdder = (aluControl == `ALU_ADD) || isSub;

	// Subtract as a + ~b + 1
	assign bInv = isSub ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, bInv} + {{`ARM_XLEN{1'b0}}, isSub};

	always_comb begin
		case (aluControl)
			`ALU_AND: result = a & b;
			`ALU_ORR: result = a | b;
			`ALU_EOR: result = a ^ b;
			`ALU_MUL: result = a * b;
			default: result = sum[`ARM_XLEN-1:0];
		endcase
	end

	assign carry = isAdder && sum[`ARM_XLEN];
	// Operands agree in sign and the sum does not
	assign overflow = isAdder && !(a[`ARM_XLEN-1] ^ b[`ARM_XLEN-1] ^ isSub)
		&& (a[`ARM_XLEN-1] ^ sum[`ARM_XLEN-1]);

	assign aluFlags = {result[`ARM_XLEN-1], result == '0, carry, overflow};

endmodule

`default_nettype wire

/* hw/mainFsm.sv */
// mainFsm: multicycle state register, next-state logic and per-state control word
`timescale 1ns/100ps
`default_nettype none

`include "arm_defines.svh"

module mainFsm (
	input  logic          clk,
	input  logic          reset,
	input  armPkg::word_t instr,
	fsmCtrlIf.fsm         fsmCtrl,
	dpCtrlIf.fsm          dpCtrl
);
	import armPkg::*;

	fsmState_t   state;
	fsmState_t   nextState;
	logic [1:0]  op;
	logic [12:0] ctrl;

	assign op = instr[27:26];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= FETCH;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		case (state)
			FETCH: nextState = DECODE;
			DECODE: begin
				case (op)
					// I bit picks the immediate operand path
					`ARM_OP_DP: nextState = instr[25] ? EXECUTEI : EXECUTER;
					`ARM_OP_MEM: nextState = MEMADR;
					`ARM_OP_BR: nextState = BRANCH;
					default: nextState = FETCH;
				endcase
			end
			// L bit separates load from store
			MEMADR: nextState = instr[20] ? MEMRD : MEMWR;
			MEMRD: nextState = MEMWB;
			EXECUTER: nextState = ALUWB;
			EXECUTEI: nextState = ALUWB;
			default: nextState = FETCH;
		endcase
	end

	// Fields: nextPc branch memW regW irWrite adrSrc resultSrc aluSrcA aluSrcB aluOp
	always_comb begin
		case (state)
			FETCH: ctrl = 13'b1_0_0_0_1_0_10_01_10_0;
			DECODE: ctrl = 13'b0_0_0_0_0_0_10_01_10_0;
			MEMADR: ctrl = 13'b0_0_0_0_0_0_00_00_01_0;
			MEMRD: ctrl = 13'b0_0_0_0_0_1_00_00_00_0;
			MEMWB: ctrl = 13'b0_0_0_1_0_0_01_00_00_0;
			MEMWR: ctrl = 13'b0_0_1_0_0_1_00_00_00_0;
			EXECUTER: ctrl = 13'b0_0_0_0_0_0_00_00_00_1;
			EXECUTEI: ctrl = 13'b0_0_0_0_0_0_00_00_01_1;
			ALUWB: ctrl = 13'b0_0_0_1_0_0_00_00_00_0;
			// Target is ALUOut (PC + 8) plus the shifted offset
			BRANCH: ctrl = 13'b0_1_0_0_0_0_10_10_01_0;
			default: ctrl = 13'b0;
		endcase
	end

	assign {fsmCtrl.nextPc, fsmCtrl.branch, fsmCtrl.memW, fsmCtrl.regW,
		dpCtrl.irWrite, dpCtrl.adrSrc, dpCtrl.resultSrc, dpCtrl.aluSrcA,
		dpCtrl.aluSrcB, fsmCtrl.aluOp} = ctrl;

	// The instruction set has no Op = 11 encoding
	decodeOpValid: assert property (@(posedge clk) disable iff (reset)
		(state == DECODE) |-> (op != 2'b11))
		else $error("Op field 11 decoded at instr %h", instr);

endmodule

`default_nettype wire

/* hw/instrDecoder.sv */
// instrDecoder: ALU decoder, flag-write select, PC-source logic, immediate and register sources
`timescale 1ns/100ps
`default_nettype none

`include "arm_defines.svh"

module instrDecoder (
	input  armPkg::word_t instr,
	fsmCtrlIf.dec         fsmCtrl,
	dpCtrlIf.dec          dpCtrl,
	output logic [1:0]    flagW,
	output logic          pcs
);
	import armPkg::*;

	logic [1:0] op;
	logic [5:0] funct;
	logic       isMul;
	logic       writesReg;
	regAddr_t   destReg;
	aluCtrl_t   aluCtl;

	assign op = instr[27:26];
	assign funct = instr[25:20];

	// Register-form DP with Funct[4:1] = 0000 and the 1001 pattern in [7:4]
	assign isMul = (op == `ARM_OP_DP) && !funct[5] && (funct[4:1] == 4'b0000)
		&& (instr[7:4] == 4'b1001);

	always_comb begin
		aluCtl = `ALU_ADD;
		flagW = 2'b00;
		if (fsmCtrl.aluOp) begin
			if (isMul) begin
				aluCtl = `ALU_MUL;
			end else begin
				case (funct[4:1])
					4'b0100: aluCtl = `ALU_ADD;
					4'b0010: aluCtl = `ALU_SUB;
					4'b0000: aluCtl = `ALU_AND;
					4'b1100: aluCtl = `ALU_ORR;
					4'b0001: aluCtl = `ALU_EOR;
					default: aluCtl = `ALU_ADD;
				endcase
			end
			// NZ follow the S bit, CV only for the adder
			flagW[1] = funct[0];
			flagW[0] = funct[0] && ((aluCtl == `ALU_ADD) || (aluCtl == `ALU_SUB));
		end
	end

	// MUL writes Rn, everything else Rd
	assign writesReg = (op == `ARM_OP_DP) || ((op == `ARM_OP_MEM) && funct[0]);
	assign destReg = isMul ? instr[19:16] : instr[15:12];
	assign pcs = fsmCtrl.branch || (writesReg && (destReg == regAddr_t'(`ARM_PC_REG)));

	assign dpCtrl.aluControl = aluCtl;
	assign dpCtrl.immSrc = srcSel_t'(op);
	// Bit 1 reads Rd for STR data, bit 0 reads r15 for branches
	assign dpCtrl.regSrc = {op == `ARM_OP_MEM, op == `ARM_OP_BR};
	assign dpCtrl.mulSel = isMul;

endmodule

`default_nettype wire

/* hw/condLogic.sv */
// condLogic: NZCV flag registers, condition check and the gated write enables
`timescale 1ns/100ps
`default_nettype none

`include "arm_defines.svh"

module condLogic (
	input  logic           clk,
	input  logic           reset,
	input  armPkg::word_t  instr,
	input  armPkg::flags_t aluFlags,
	input  logic [1:0]     flagW,
	input  logic           pcs,
	fsmCtrlIf.cond         fsmCtrl,
	dpCtrlIf.cond          dpCtrl,
	output logic           memWrite
);
	import armPkg::*;

	cond_t      cond;
	flags_t     flags;
	logic       condEx;
	logic       condExReg;
	logic [1:0] flagWrite;
	logic       n, z, c, v;
	logic       ge;

	assign cond = instr[31:28];
	assign {n, z, c, v} = flags;
	assign ge = (n == v);

	always_comb begin
		case (cond)
			4'b0000: condEx = z;
			4'b0001: condEx = !z;
			4'b0010: condEx = c;
			4'b0011: condEx = !c;
			4'b0100: condEx = n;
			4'b0101: condEx = !n;
			4'b0110: condEx = v;
			4'b0111: condEx = !v;
			4'b1000: condEx = c && !z;
			4'b1001: condEx = !(c && !z);
			4'b1010: condEx = ge;
			4'b1011: condEx = !ge;
			4'b1100: condEx = !z && ge;
			4'b1101: condEx = !(!z && ge);
			`ARM_COND_AL: condEx = 1'b1;
			default: condEx = 1'b0;
		endcase
	end

	// Flags update in the execute cycle, before they change
	assign flagWrite = flagW & {2{condEx}};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			flags <= '0;
			condExReg <= 1'b0;
		end else begin
			if (flagWrite[1]) begin
				flags[3:2] <= aluFlags[3:2];
			end
			if (flagWrite[0]) begin
				flags[1:0] <= aluFlags[1:0];
			end
			condExReg <= condEx;
		end
	end

	// Writeback cycles use the result held from the cycle before
	assign dpCtrl.regWrite = fsmCtrl.regW && condExReg;
	assign memWrite = fsmCtrl.memW && condExReg;
	assign dpCtrl.pcWrite = (pcs && (fsmCtrl.branch || fsmCtrl.regW) && condExReg)
		|| fsmCtrl.nextPc;

	// Stores and register writebacks live in different states
	noMemRegOverlap: assert property (@(posedge clk) disable iff (reset)
		!(memWrite && dpCtrl.regWrite))
		else $error("memWrite and regWrite both high");

endmodule

`default_nettype wire

/* hw/datapath.sv */
// datapath: PC, instruction and data registers, register file, extender and operand selects
`timescale 1ns/100ps
`default_nettype none

`include "arm_defines.svh"

module datapath (
	input  logic           clk,
	input  logic           reset,
	input  armPkg::word_t  readData,
	output armPkg::word_t  memAdr,
	output armPkg::word_t  writeData,
	output armPkg::word_t  instr,
	output armPkg::flags_t aluFlags,
	dpCtrlIf.dp            dpCtrl
);
	import armPkg::*;

	word_t    pc;
	word_t    data;
	word_t    aReg;
	word_t    aluOut;
	word_t    aluResult;
	word_t    result;
	word_t    extImm;
	word_t    srcA;
	word_t    srcB;
	word_t    rd1;
	word_t    rd2;
	regAddr_t ra1;
	regAddr_t ra2;
	regAddr_t a3;

	// r0 to r14, r15 is not stored
	word_t regFile [`ARM_NREGS-2:0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
			instr <= '0;
		end else begin
			if (dpCtrl.pcWrite) begin
				pc <= result;
			end
			if (dpCtrl.irWrite) begin
				instr <= readData;
			end
		end
	end

	assign memAdr = dpCtrl.adrSrc ? result : pc;

	always_ff @(posedge clk) begin
		data <= readData;
		aReg <= rd1;
		writeData <= rd2;
		aluOut <= aluResult;
	end

	// MUL reads Rm and Rs and writes Rn
	always_comb begin
		if (dpCtrl.regSrc[0]) begin
			ra1 = regAddr_t'(`ARM_PC_REG);
		end else begin
			ra1 = dpCtrl.mulSel ? instr[3:0] : instr[19:16];
		end
		if (dpCtrl.regSrc[1]) begin
			ra2 = instr[15:12];
		end else begin
			ra2 = dpCtrl.mulSel ? instr[11:8] : instr[3:0];
		end
		a3 = dpCtrl.mulSel ? instr[19:16] : instr[15:12];
	end

	always_ff @(posedge clk) begin
		if (dpCtrl.regWrite && (a3 != regAddr_t'(`ARM_PC_REG))) begin
			regFile[a3] <= result;
		end
	end

	// r15 reads the result bus, PC + 8 during DECODE
	assign rd1 = (ra1 == regAddr_t'(`ARM_PC_REG)) ? result : regFile[ra1];
	assign rd2 = (ra2 == regAddr_t'(`ARM_PC_REG)) ? result : regFile[ra2];

	always_comb begin
		case (dpCtrl.immSrc)
			2'b00: extImm = {24'b0, instr[7:0]};
			2'b01: extImm = {20'b0, instr[11:0]};
			// Word offset, sign extended
			2'b10: extImm = {{6{instr[23]}}, instr[23:0], 2'b00};
			default: extImm = '0;
		endcase
	end

	always_comb begin
		case (dpCtrl.aluSrcA)
			2'b00: srcA = aReg;
			2'b01: srcA = pc;
			default: srcA = aluOut;
		endcase
		case (dpCtrl.aluSrcB)
			2'b00: srcB = writeData;
			2'b01: srcB = extImm;
			default: srcB = word_t'(4);
		endcase
		case (dpCtrl.resultSrc)
			2'b00: result = aluOut;
			2'b01: result = data;
			default: result = aluResult;
		endcase
	end

	alu alu_inst (
		.a(srcA),
		.b(srcB),
		.aluControl(dpCtrl.aluControl),
		.result(aluResult),
		.aluFlags(aluFlags)
	);

endmodule

`default_nettype wire

/* hw/armCpu.sv */
// armCpu: processor top level with the control interfaces and a plain memory bus
`timescale 1ns/100ps
`default_nettype none

module armCpu (
	input  logic          clk,
	input  logic          reset,
	input  armPkg::word_t readData,
	output armPkg::word_t memAdr,
	output armPkg::word_t writeData,
	output logic          memWrite
);
	import armPkg::*;

	word_t      instr;
	flags_t     aluFlags;
	logic [1:0] flagW;
	logic       pcs;

	fsmCtrlIf fsmCtrl ();
	dpCtrlIf  dpCtrl ();

	mainFsm mainFsm_inst (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.fsmCtrl(fsmCtrl.fsm),
		.dpCtrl(dpCtrl.fsm)
	);

	instrDecoder instrDecoder_inst (
		.instr(instr),
		.fsmCtrl(fsmCtrl.dec),
		.dpCtrl(dpCtrl.dec),
		.flagW(flagW),
		.pcs(pcs)
	);

	condLogic condLogic_inst (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.aluFlags(aluFlags),
		.flagW(flagW),
		.pcs(pcs),
		.fsmCtrl(fsmCtrl.cond),
		.dpCtrl(dpCtrl.cond),
		.memWrite(memWrite)
	);

	datapath datapath_inst (
		.clk(clk),
		.reset(reset),
		.readData(readData),
		.memAdr(memAdr),
		.writeData(writeData),
		.instr(instr),
		.aluFlags(aluFlags),
		.dpCtrl(dpCtrl.dp)
	);

endmodule

`default_nettype wire

/* test/armIsaModel.svh */
// Reference ISA model, instruction encoders, condition and ALU rules, Galois LFSR step
`ifndef ARM_ISA_MODEL_SVH
`define ARM_ISA_MODEL_SVH

// Software copy of the architectural state
word_t  refRegs [0:14];
flags_t refFlags;
word_t  refMem [0:MEM_WORDS-1];
word_t  expAdr [$];
word_t  expData [$];
int     modelSteps;

// Taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] galoisStep(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic word_t encDp(input logic [3:0] cond, input logic imm, input logic [3:0] cmd,
	input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] op2);
	return {cond, 2'b00, imm, cmd, s, rn, rd, op2};
endfunction

// Rd sits in the Rn field, Rs in [11:8], Rm in [3:0]
function automatic word_t encMul(input logic [3:0] cond, input logic s, input logic [3:0] rd,
	input logic [3:0] rm, input logic [3:0] rs);
	return {cond, 7'b0, s, rd, 4'b0, rs, 4'b1001, rm};
endfunction

// Pre-indexed, offset added, no writeback
function automatic word_t encMem(input logic [3:0] cond, input logic load, input logic [3:0] rn,
	input logic [3:0] rd, input logic [11:0] imm12);
	return {cond, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, imm12};
endfunction

function automatic word_t encBr(input logic [3:0] cond, input logic [23:0] off);
	return {cond, 4'b1010, off};
endfunction

function automatic logic condPasses(input logic [3:0] cond, input flags_t f);
	logic n, z, c, v;
	{n, z, c, v} = f;
	case (cond)
		4'h0: return z;
		4'h1: return !z;
		4'h2: return c;
		4'h3: return !c;
		4'h4: return n;
		4'h5: return !n;
		4'h6: return v;
		4'h7: return !v;
		4'h8: return c && !z;
		4'h9: return !c || z;
		4'hA: return n == v;
		4'hB: return n != v;
		4'hC: return !z && (n == v);
		4'hD: return z || (n != v);
		4'hE: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

// Kind is the DP cmd field, or 4'hF for multiply
function automatic word_t aluRef(input logic [3:0] kind, input word_t a, input word_t b,
	output flags_t f);
	word_t r;
	logic [32:0] wide;
	f = '0;
	case (kind)
		4'b0100: begin
			wide = {1'b0, a} + {1'b0, b};
			r = wide[31:0];
			f[1] = wide[32];
			f[0] = (a[31] == b[31]) && (r[31] != a[31]);
		end
		4'b0010: begin
			r = a - b;
			// Carry means no borrow
			f[1] = (a >= b);
			f[0] = (a[31] != b[31]) && (r[31] != a[31]);
		end
		4'b0000: r = a & b;
		4'b1100: r = a | b;
		4'b0001: r = a ^ b;
		default: r = a * b;
	endcase
	f[3] = r[31];
	f[2] = (r == 32'h0);
	return r;
endfunction

function automatic word_t readReg(input logic [3:0] idx, input word_t pc);
	return (idx == 4'hF) ? pc + `ARM_PC_AHEAD : refRegs[idx];
endfunction

// Steps the program from address 0 to the halt loop
task automatic runModel();
	word_t pc, w, a, b, r, addr, nextPc;
	flags_t f;
	logic pass;
	logic isMul;
	pc = '0;
	refFlags = '0;
	modelSteps = 0;
	while (pc != haltAddr && modelSteps <= 2000) begin
		w = refMem[pc[11:2]];
		pass = condPasses(w[31:28], refFlags);
		isMul = !w[25] && (w[24:21] == 4'b0000) && (w[7:4] == 4'b1001);
		nextPc = pc + 4;
		modelSteps++;
		case (w[27:26])
			2'b00: begin
				if (isMul) begin
					a = readReg(w[3:0], pc);
					b = readReg(w[11:8], pc);
					r = aluRef(4'hF, a, b, f);
					if (pass && w[19:16] != 4'hF) refRegs[w[19:16]] = r;
				end else begin
					a = readReg(w[19:16], pc);
					b = w[25] ? {24'h0, w[7:0]} : readReg(w[3:0], pc);
					r = aluRef(w[24:21], a, b, f);
					if (pass && w[15:12] != 4'hF) refRegs[w[15:12]] = r;
				end
				if (pass && w[20]) begin
					refFlags[3:2] = f[3:2];
					if (!isMul && (w[24:21] == 4'b0100 || w[24:21] == 4'b0010))
						refFlags[1:0] = f[1:0];
				end
			end
			2'b01: begin
				addr = readReg(w[19:16], pc) + {20'h0, w[11:0]};
				if (pass && w[20] && w[15:12] != 4'hF) begin
					refRegs[w[15:12]] = refMem[addr[11:2]];
				end else if (pass && !w[20]) begin
					refMem[addr[11:2]] = readReg(w[15:12], pc);
					expAdr.push_back(addr);
					expData.push_back(readReg(w[15:12], pc));
				end
			end
			default: if (pass) nextPc = pc + `ARM_PC_AHEAD + {{6{w[23]}}, w[23:0], 2'b00};
		endcase
		pc = nextPc;
	end
endtask

`endif

/* test/armCpuTb.sv */
// armCpuTb: clock, reset, memory model, random program, store checker and watchdog
`timescale 1ns/100ps
`default_nettype none

`include "arm_defines.svh"

module armCpuTb;
	import armPkg::*;

	localparam int MEM_WORDS = 1024;
	localparam int N_RANDOM = 60;

	logic        clk = 1'b0;
	logic        reset;
	word_t       readData;
	word_t       memAdr;
	word_t       writeData;
	logic        memWrite;
	word_t       mem [0:MEM_WORDS-1];
	word_t       image [0:MEM_WORDS-1];
	logic [31:0] lfsrState = 32'h5a52_1e53;
	word_t       haltAddr;
	int          storesSeen = 0;
	int          timeLimit;
	logic        modelReady = 1'b0;

	`include "armIsaModel.svh"

	always #4 clk = ~clk;

	armCpu armCpu_inst (
		.clk(clk),
		.reset(reset),
		.readData(readData),
		.memAdr(memAdr),
		.writeData(writeData),
		.memWrite(memWrite)
	);

	// Program image reloads while reset is high
	assign readData = mem[memAdr[11:2]];
	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < MEM_WORDS; i++) mem[i] <= image[i];
		end else if (memWrite) begin
			mem[memAdr[11:2]] <= writeData;
		end
	end

	task automatic reportMismatch(input string name, input word_t expected, input word_t actual);
		$display("[FAIL] %s expected %h got %h", name, expected, actual);
		$display("TB FAILED");
		$fatal(1, "value mismatch");
	endtask

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run aborted");
	endtask

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = galoisStep(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	function automatic logic [3:0] pickReg(input logic dest);
		logic [31:0] v;
		v = randBits(4);
		// r13 is the data base and stays zero
		if (v[3:0] == 4'hF || (dest && v[3:0] == 4'hD)) return 4'hE;
		return v[3:0];
	endfunction

	task automatic genProgram();
		int n;
		logic [31:0] kind, cm, cond, s, imm, k8, k6, off;
		logic [3:0] rn, rd, rs, cmd, cc;
		for (int i = 0; i < MEM_WORDS; i++) image[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h5bd1_e995;
		n = 0;
		for (int r = 0; r < 15; r++) begin
			image[n] = encDp(`ARM_COND_AL, 1'b1, 4'b0000, 1'b0, 4'(r), 4'(r), 12'h0);
			n++;
		end
		for (int r = 0; r < 15; r++) begin
			if (r != 13) begin
				k8 = randBits(8);
				image[n] = encDp(`ARM_COND_AL, 1'b1, 4'b1100, 1'b0, 4'(r), 4'(r), {4'h0, k8[7:0]});
				n++;
			end
		end
		for (int k = 0; k < N_RANDOM; k++) begin
			kind = randBits(3);
			cond = randBits(5);
			rn = pickReg(1'b0);
			rd = pickReg(1'b1);
			rs = pickReg(1'b0);
			s = randBits(1);
			imm = randBits(1);
			cm = randBits(3);
			k8 = randBits(8);
			k6 = randBits(6);
			off = randBits(2);
			// Half the instructions run always, the rest take one of 15 codes
			cc = (cond[4] || cond[3:0] == 4'hF) ? `ARM_COND_AL : cond[3:0];
			// Forward branches never land past the epilogue start
			if (kind[2:0] == 3'd7 && k > N_RANDOM - 5) kind = 0;
			case (cm[2:0] % 5)
				0: cmd = 4'b0100;
				1: cmd = 4'b0010;
				2: cmd = 4'b0000;
				3: cmd = 4'b1100;
				default: cmd = 4'b0001;
			endcase
			case (kind[2:0])
				3'd4: image[n] = encMul(cc, s[0], rd, rn, rs);
				3'd5: image[n] = encMem(cc, 1'b1, 4'hD, rd, {4'h8, k6[5:0], 2'b00});
				3'd6: image[n] = encMem(cc, 1'b0, 4'hD, rn, {4'h8, k6[5:0], 2'b00});
				3'd7: image[n] = encBr(cc, {22'h0, off[1:0]});
				default: image[n] = encDp(cc, imm[0], cmd, s[0], rn, rd,
					imm[0] ? {4'h0, k8[7:0]} : {8'h00, rs});
			endcase
			n++;
		end
		for (int r = 0; r < 15; r++) begin
			image[n] = encMem(`ARM_COND_AL, 1'b0, 4'hD, 4'(r), 12'hC00 + 12'(4 * r));
			n++;
		end
		haltAddr = 32'(n * 4);
		image[n] = encBr(`ARM_COND_AL, 24'hFF_FFFE);
	endtask

	// Every DUT store is compared in order with the model's list
	always @(posedge clk) begin
		if (!reset && memWrite) begin
			if (storesSeen >= expAdr.size()) begin
				abortRun("DUT issued a store that the reference model does not predict");
			end else begin
				assert (memAdr == expAdr[storesSeen])
					else reportMismatch("memAdr", expAdr[storesSeen], memAdr);
				assert (writeData == expData[storesSeen])
					else reportMismatch("writeData", expData[storesSeen], writeData);
				storesSeen++;
			end
		end
	end

	initial begin
		wait (modelReady);
		#(timeLimit);
		$display("Watchdog expired before the program reached its halt loop");
		$display("TB FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		reset = 1'b1;
		genProgram();
		for (int i = 0; i < MEM_WORDS; i++) refMem[i] = image[i];
		runModel();
		if (modelSteps > 2000) begin
			abortRun("Reference model never reached the halt loop");
		end else begin
			// Five cycles per instruction at 8 ns, plus reset and margin
			timeLimit = modelSteps * 5 * 8 + 4 * 8 + 800;
			modelReady = 1'b1;
			repeat (4) begin
				@(negedge clk);
				assert (memWrite == 1'b0) else reportMismatch("memWrite", 32'h0, 32'(memWrite));
			end
			@(posedge clk);
			reset <= 1'b0;
			@(negedge clk);
			assert (memAdr == 32'h0) else reportMismatch("memAdr", 32'h0, memAdr);
			assert (memWrite == 1'b0) else reportMismatch("memWrite", 32'h0, 32'(memWrite));
			while (!(storesSeen == expAdr.size() && memAdr == haltAddr)) @(negedge clk);
			// Four turns of the 3-cycle halt loop catch stray stores and end in its FETCH
			repeat (12) @(negedge clk);
			assert (memAdr == haltAddr) else reportMismatch("memAdr", haltAddr, memAdr);
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
+incdir+test
hw/armPkg.sv
hw/armIfc.sv
hw/alu.sv
hw/mainFsm.sv
hw/instrDecoder.sv
hw/condLogic.sv
hw/datapath.sv
hw/armCpu.sv
test/armCpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= armCpuTb
RTL_TOP ?= armCpu
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
